/* compile.f */
hw/MidiPkg.sv
hw/UartRx.sv
hw/MidiParser.sv
hw/NoteFreqLookup.sv
hw/ToneGen.sv
hw/MidiSynthTop.sv
testbench/tbMidiSynth.sv

/* Bender.yml */
package:
  name: midi_synth

sources:
  # RTL, package first
  - hw/MidiPkg.sv
  - hw/UartRx.sv
  - hw/MidiParser.sv
  - hw/NoteFreqLookup.sv
  - hw/ToneGen.sv
  - hw/MidiSynthTop.sv

  # testbench
  - target: simulation
    files:
      - testbench/tbMidiSynth.sv

/* testbench/tbMidiSynth.sv */
// runs the DUT at 16 clocks per bit; outputs are checked 4 clocks after each message's last stop bit
`timescale 1ns/1ns
module tbMidiSynth;

	localparam int     BitClks   = 16;
	localparam int     ClkNs     = 8;
	localparam int     NumMsgs   = 40;
	localparam longint Window    = 200000;
	localparam longint MsgNs     = longint'(NumMsgs) * 3 * 10 * BitClks * ClkNs * 2;
	localparam longint ToneNs    = 20 * (Window + 3 * 10 * BitClks * 2) * ClkNs;
	localparam longint TimeoutNs = MsgNs + ToneNs + 1000;

	logic             iSCLK;
	logic             iSRST;
	logic             midiIn;
	MidiPkg::noteNumT noteNum;
	MidiPkg::freqHzT  noteFreq;
	logic             notePlay;
	logic             audio;

	integer seed;
	int     errCount;
	int     checkCount;

	// reference model state
	logic [6:0] expNote;
	logic       expPlay;
	logic [7:0] lastStatus;

	MidiSynthTop #(
		.BaudDiv(BitClks)
	) u_dut (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.midiIn  (midiIn),
		.noteNum (noteNum),
		.noteFreq(noteFreq),
		.notePlay(notePlay),
		.audio   (audio)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #(ClkNs / 2) iSCLK = ~iSCLK;
	end

	initial
	begin
		#(TimeoutNs);
		$display("timeout, the run did not finish within %0d ns", TimeoutNs);
		$display("TEST FAIL");
		$finish;
	end

	// --------------------
	// reference pitch
	// --------------------
	// octave shift of the top octave, notes 120 to 131
	function automatic logic [15:0] freqOf(input logic [6:0] n);
		logic [15:0] top;
		int          oct;
		oct = n / 12;
		case (n % 12)
			0:       top = 16'd8373;
			1:       top = 16'd8870;
			2:       top = 16'd9398;
			3:       top = 16'd9957;
			4:       top = 16'd10549;
			5:       top = 16'd11176;
			6:       top = 16'd11840;
			7:       top = 16'd12544;
			8:       top = 16'd13290;
			9:       top = 16'd14080;
			10:      top = 16'd14917;
			default: top = 16'd15804;
		endcase
		return top >> (10 - oct);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		assert (got === want)
		else
		begin
			errCount++;
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	// --------------------
	// serial driver
	// --------------------
	task automatic driveBit(input logic b);
		@(posedge iSCLK);
		#1;
		midiIn = b;
		repeat (BitClks - 1) @(posedge iSCLK);
	endtask

	task automatic sendByte(input logic [7:0] b);
		int i;
		driveBit(1'b0);
		for (i = 0; i < 8; i++)
			driveBit(b[i]);
		driveBit(1'b1);
	endtask

	// one clock to the end of the stop bit, then four more
	task automatic checkOutputs();
		repeat (5) @(posedge iSCLK);
		#1;
		checkValue("noteNum", noteNum, expNote);
		checkValue("notePlay", notePlay, expPlay);
		checkValue("noteFreq", noteFreq, freqOf(expNote));
		if (!expPlay)
			checkValue("audio", audio, 1'b0);
	endtask

	// --------------------
	// random messages
	// --------------------
	// kind 0 note-on, 1 note-off, 2 note-on with velocity zero, 3 control change
	task automatic sendRandomMessage();
		int         kind;
		int         txLen;
		int         i;
		logic [3:0] chan;
		logic [7:0] status;
		logic [6:0] note;
		logic [6:0] vel;
		logic       runStatus;
		logic [7:0] txBuf [0:3];
		kind = $random(seed) & 3;
		chan = $random(seed) & 3;
		if (kind == 1)
			status = {4'h8, chan};
		else if (kind == 3)
			status = {4'hB, chan};
		else
			status = {4'h9, chan};
		note = 7'($random(seed));
		if ((kind == 1 || kind == 2) && ($random(seed) & 1))
			note = expNote;
		vel = 7'($random(seed));
		if (kind == 0 && vel == 7'd0)
			vel = 7'd1;
		if (kind == 2)
			vel = 7'd0;
		runStatus = (status == lastStatus) && (($random(seed) & 3) != 0);
		txLen = 0;
		if (!runStatus)
		begin
			txBuf[txLen] = status;
			txLen++;
		end
		txBuf[txLen] = {1'b0, note};
		txLen++;
		// timing clock byte between the data bytes
		if (($random(seed) & 3) == 0)
		begin
			txBuf[txLen] = 8'hF8;
			txLen++;
		end
		txBuf[txLen] = {1'b0, vel};
		txLen++;
		for (i = 0; i < txLen; i++)
			sendByte(txBuf[i]);
		lastStatus = status;
		if (kind == 0)
		begin
			expNote = note;
			expPlay = 1'b1;
		end
		else if (kind != 3 && note == expNote)
			expPlay = 1'b0;
		checkOutputs();
	endtask

	// --------------------
	// tone rate
	// --------------------
	task automatic playAndCount(input logic [6:0] n);
		int     edges;
		int     i;
		logic   prevAudio;
		longint want;
		longint diff;
		sendByte(8'h90);
		sendByte({1'b0, n});
		sendByte(8'h64);
		lastStatus = 8'h90;
		expNote = n;
		expPlay = 1'b1;
		checkOutputs();
		edges = 0;
		prevAudio = audio;
		for (i = 0; i < Window; i++)
		begin
			@(posedge iSCLK);
			#1;
			if (audio && !prevAudio)
				edges++;
			prevAudio = audio;
		end
		want = (longint'(freqOf(n)) * longint'(MidiPkg::PhaseStep) * Window) >> 32;
		diff = edges - want;
		checkCount++;
		assert (diff >= -2 && diff <= 2)
		else
		begin
			errCount++;
			$display("ERROR audio edges for note 0x%0h got 0x%0h expected 0x%0h", n, edges, want);
		end
	endtask

	initial
	begin : mainFlow
		int n;
		seed = 83;
		errCount = 0;
		checkCount = 0;
		expNote = 7'd0;
		expPlay = 1'b0;
		lastStatus = 8'h00;
		iSRST = 1'b1;
		midiIn = 1'b1;
		repeat (2) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
		// reset state, note 0 silent
		checkOutputs();
		for (n = 0; n < NumMsgs; n++)
			sendRandomMessage();
		for (n = 108; n <= 127; n++)
			playAndCount(7'(n));
		$display("checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hw/MidiSynthTop.sv */
// MIDI in to square-wave tone; BaudDiv sets clocks per bit, default is 31250 baud at 100 MHz
`timescale 1ns/1ns
module MidiSynthTop #(
	parameter int BaudDiv = MidiPkg::DefaultBaudDiv
) (
	input  logic             iSCLK,
	input  logic             iSRST,
	input  logic             midiIn,
	output MidiPkg::noteNumT noteNum,
	output MidiPkg::freqHzT  noteFreq,
	output logic             notePlay,
	output logic             audio
);

	MidiPkg::midiByteT  rxByte;
	logic               rxValid;
	MidiPkg::noteEventT evData;
	logic               evValid;

	// --------------------
	// serial in and parse
	// --------------------
	UartRx #(
		.BaudDiv(BaudDiv)
	) uRx (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.serialIn(midiIn),
		.rxByte  (rxByte),
		.rxValid (rxValid)
	);

	MidiParser uParser (
		.iSCLK  (iSCLK),
		.iSRST  (iSRST),
		.rxByte (rxByte),
		.rxValid(rxValid),
		.evData (evData),
		.evValid(evValid)
	);

	// --------------------
	// pitch and tone
	// --------------------
	NoteFreqLookup uLookup (
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.note  (noteNum),
		.freqHz(noteFreq)
	);

	ToneGen uTone (
		.iSCLK  (iSCLK),
		.iSRST  (iSRST),
		.evData (evData),
		.evValid(evValid),
		.freqHz (noteFreq),
		.curNote(noteNum),
		.playing(notePlay),
		.audio  (audio)
	);

endmodule

/* hw/ToneGen.sv */
// monophonic square wave; note-off only acts on the sounding note, frequency lags note by one cycle
`timescale 1ns/1ns
module ToneGen (
	input  logic               iSCLK,
	input  logic               iSRST,
	input  MidiPkg::noteEventT evData,
	input  logic               evValid,
	input  MidiPkg::freqHzT    freqHz,
	output MidiPkg::noteNumT   curNote,
	output logic               playing,
	output logic               audio
);

	MidiPkg::noteNumT noteNext;
	logic             playNext;
	MidiPkg::phaseT   phaseInc;
	MidiPkg::phaseT   phase;

	// --------------------
	// note state
	// --------------------
	always_comb
	begin
		noteNext = curNote;
		playNext = playing;
		if (evValid)
		begin
			if (evData.noteOn)
			begin
				noteNext = evData.note;
				playNext = 1'b1;
			end
			else if (evData.note == curNote)
				playNext = 1'b0;
		end
		phaseInc = MidiPkg::phaseT'(freqHz) * MidiPkg::PhaseStep;
	end

	// --------------------
	// phase accumulator
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			curNote <= '0;
			playing <= 1'b0;
			phase   <= '0;
		end
		else
		begin
			curNote <= noteNext;
			playing <= playNext;
			// cleared together with playing so audio drops at once
			if (playNext)
				phase <= phase + phaseInc;
			else
				phase <= '0;
		end
	end

	assign audio = phase[31];

	// silence must follow the note state in the same cycle
	assert property (@(posedge iSCLK) disable iff (iSRST) !playing |-> !audio);

endmodule

/* hw/NoteFreqLookup.sv */
// note to whole hertz, octave shift of the top-octave table; one cycle latency
`timescale 1ns/1ns
module NoteFreqLookup (
	input  logic             iSCLK,
	input  logic             iSRST,
	input  MidiPkg::noteNumT note,
	output MidiPkg::freqHzT  freqHz
);

	logic [3:0]      octave;
	logic [3:0]      index;
	logic [3:0]      shiftAmt;
	MidiPkg::freqHzT tableHz;

	// --------------------
	// split note into octave and pitch class
	// --------------------
	always_comb
	begin
		octave   = 4'(note / 7'd12);
		index    = 4'(note % 7'd12);
		// octave 10 is the table itself
		shiftAmt = 4'd10 - octave;
		tableHz  = MidiPkg::TopOctaveHz[index];
	end

	// note 0 result after reset matches curNote 0
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			freqHz <= MidiPkg::TopOctaveHz[0] >> 10;
		else
			freqHz <= tableHz >> shiftAmt;
	end

endmodule

/* hw/MidiParser.sv */
// note-on and note-off only, any channel; other messages are skipped, real-time bytes ignored
`timescale 1ns/1ns
module MidiParser (
	input  logic               iSCLK,
	input  logic               iSRST,
	input  MidiPkg::midiByteT  rxByte,
	input  logic               rxValid,
	output MidiPkg::noteEventT evData,
	output logic               evValid
);

	MidiPkg::parseStateT state;
	MidiPkg::noteNumT    noteReg;
	logic                statusOn;
	logic                isRealTime;
	logic                isStatus;
	logic [3:0]          statusNib;

	assign isRealTime = (rxByte >= 8'hF8);
	assign isStatus   = rxByte[7];
	assign statusNib  = rxByte[7:4];

	// --------------------
	// message FSM
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= MidiPkg::idle;
			statusOn <= 1'b0;
			evValid  <= 1'b0;
		end
		else
		begin
			evValid <= 1'b0;
			if (rxValid && !isRealTime)
			begin
				if (isStatus)
				begin
					// remembered for running status
					if (statusNib == 4'h9 || statusNib == 4'h8)
					begin
						statusOn <= (statusNib == 4'h9);
						state    <= MidiPkg::waitNote;
					end
					else
						state <= MidiPkg::skipData;
				end
				else
				begin
					case (state)
						MidiPkg::waitNote:
							state <= MidiPkg::waitVelocity;
						MidiPkg::waitVelocity:
						begin
							evValid <= 1'b1;
							state   <= MidiPkg::waitNote;
						end
						// data with no usable status stays put
						MidiPkg::idle,
						MidiPkg::skipData:
							state <= state;
						default:
							state <= MidiPkg::idle;
					endcase
				end
			end
		end
	end

	// --------------------
	// payload
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (rxValid && !isStatus)
		begin
			if (state == MidiPkg::waitNote)
				noteReg <= rxByte[6:0];
			if (state == MidiPkg::waitVelocity)
			begin
				evData.note   <= noteReg;
				// velocity zero on a note-on counts as note-off
				evData.noteOn <= statusOn && (rxByte[6:0] != 7'd0);
			end
		end
	end

	// each event is the direct result of a received velocity byte
	assert property (@(posedge iSCLK) disable iff (iSRST) evValid |-> $past(rxValid));

endmodule

/* hw/UartRx.sv */
// 8N1 receiver, LSB first, no parity; a low stop bit drops the byte and waits for idle high
`timescale 1ns/1ns
module UartRx #(
	parameter int BaudDiv = MidiPkg::DefaultBaudDiv
) (
	input  logic              iSCLK,
	input  logic              iSRST,
	input  logic              serialIn,
	output MidiPkg::midiByteT rxByte,
	output logic              rxValid
);

	localparam int CntW = $clog2(BaudDiv);
	localparam logic [CntW-1:0] HalfBit = CntW'(BaudDiv / 2 - 1);
	localparam logic [CntW-1:0] FullBit = CntW'(BaudDiv - 1);

	typedef enum logic [2:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop,
		rxWaitHigh
	} rxStateT;

	rxStateT           state;
	logic [CntW-1:0]   cnt;
	logic [2:0]        bitIdx;
	logic [1:0]        syncReg;
	logic              lineIn;
	MidiPkg::midiByteT shiftReg;

	// --------------------
	// input synchronizer
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			syncReg <= 2'b11;
		else
			syncReg <= {syncReg[0], serialIn};
	end

	assign lineIn = syncReg[1];

	// --------------------
	// bit timing FSM
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= rxIdle;
			cnt     <= '0;
			bitIdx  <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			case (state)
				rxIdle:
				begin
					cnt <= '0;
					if (!lineIn)
						state <= rxStart;
				end
				// still low at half a bit means a real start bit
				rxStart:
				begin
					if (cnt == HalfBit)
					begin
						cnt    <= '0;
						bitIdx <= '0;
						state  <= lineIn ? rxIdle : rxData;
					end
					else
						cnt <= cnt + 1'b1;
				end
				rxData:
				begin
					if (cnt == FullBit)
					begin
						cnt    <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= rxStop;
					end
					else
						cnt <= cnt + 1'b1;
				end
				rxStop:
				begin
					if (cnt == FullBit)
					begin
						cnt     <= '0;
						rxValid <= lineIn;
						state   <= lineIn ? rxIdle : rxWaitHigh;
					end
					else
						cnt <= cnt + 1'b1;
				end
				// framing error, hold off until the line idles
				rxWaitHigh:
				begin
					if (lineIn)
						state <= rxIdle;
				end
				default:
					state <= rxIdle;
			endcase
		end
	end

	// data shift, mid-bit sample
	always_ff @(posedge iSCLK)
	begin
		if (state == rxData && cnt == FullBit)
			shiftReg <= {lineIn, shiftReg[7:1]};
	end

	assign rxByte = shiftReg;

	// a byte takes ten bit times, so strobes never touch
	assert property (@(posedge iSCLK) disable iff (iSRST) rxValid |=> !rxValid);

endmodule

/* hw/MidiPkg.sv */
// shared MIDI synth types and constants; assumes a 100 MHz clock and 31250 baud MIDI
package MidiPkg;

	// --------------------
	// timing
	// --------------------
	localparam int ClkHz = 100_000_000;

	// clocks per MIDI bit at 31250 baud
	localparam int DefaultBaudDiv = ClkHz / 31_250;

	// --------------------
	// widths
	// --------------------
	typedef logic [7:0]  midiByteT;
	typedef logic [6:0]  noteNumT;
	typedef logic [15:0] freqHzT;
	typedef logic [31:0] phaseT;

	// phase increment per hertz, 2^32 / ClkHz rounded
	localparam phaseT PhaseStep = 32'd43;

	// one decoded note message, valid strobe travels alongside
	typedef struct packed {
		logic    noteOn;
		noteNumT note;
	} noteEventT;

	// parser states
	typedef enum logic [1:0] {
		idle,
		waitNote,
		waitVelocity,
		skipData
	} parseStateT;

	// --------------------
	// top octave, notes 120 to 131
	// --------------------
	// lower octaves are these values shifted right
	localparam freqHzT TopOctaveHz [0:11] = '{
		16'd8373,  16'd8870,  16'd9398,  16'd9957,
		16'd10549, 16'd11176, 16'd11840, 16'd12544,
		16'd13290, 16'd14080, 16'd14917, 16'd15804
	};

endpackage
